/* rtl/mem_sys_pkg.sv */
package mem_sys_pkg;

  // bus widths shared by every block
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // byte offset bits inside one word
  localparam int word_lsb = 2;

  // operation carried on the internal memory request bus
  typedef enum logic {
    mem_read,
    mem_write
  } mem_op_t;

  // data cache miss handling
  typedef enum logic [1:0] {
    cache_idle,
    cache_writeback,
    cache_refill,
    cache_respond
  } cache_state_t;

  // owner of the shared memory port
  typedef enum logic {
    grant_fetch,
    grant_cache
  } grant_t;

endpackage

/* rtl/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port (
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               fetch_arvalid,
  output logic                               fetch_arready,
  input  logic [mem_sys_pkg::addr_width-1:0] fetch_araddr,
  output logic                               fetch_rvalid,
  input  logic                               fetch_rready,
  output logic [mem_sys_pkg::data_width-1:0] fetch_rdata,
  output logic                               req_valid,
  input  logic                               req_ready,
  output logic [mem_sys_pkg::addr_width-1:0] req_addr,
  input  logic                               rsp_valid,
  input  logic [mem_sys_pkg::data_width-1:0] rsp_rdata
);

  logic                               buf_valid;
  logic [mem_sys_pkg::addr_width-1:0] buf_addr;
  logic                               in_flight;

  // one address can wait here while the response register is busy
  assign fetch_arready = !buf_valid;

  // a read goes out only when its response has somewhere to land
  assign req_valid = buf_valid && !in_flight && !fetch_rvalid;
  assign req_addr  = buf_addr;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      buf_valid    <= 1'b0;
      in_flight    <= 1'b0;
      fetch_rvalid <= 1'b0;
    end else begin
      if (fetch_arvalid && fetch_arready) begin
        buf_valid <= 1'b1;
      end else if (req_valid && req_ready) begin
        buf_valid <= 1'b0;
      end

      if (req_valid && req_ready) begin
        in_flight <= 1'b1;
      end else if (rsp_valid) begin
        in_flight <= 1'b0;
      end

      if (rsp_valid) begin
        fetch_rvalid <= 1'b1;
      end else if (fetch_rvalid && fetch_rready) begin
        fetch_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (fetch_arvalid && fetch_arready) begin
      buf_addr <= fetch_araddr;
    end
    if (rsp_valid) begin
      fetch_rdata <= rsp_rdata;
    end
  end

endmodule

/* rtl/wb_cache.sv */
`timescale 1ns/1ps

module wb_cache #(
  parameter int num_sets = 4
) (
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               data_arvalid,
  output logic                               data_arready,
  input  logic [mem_sys_pkg::addr_width-1:0] data_araddr,
  output logic                               data_rvalid,
  input  logic                               data_rready,
  output logic [mem_sys_pkg::data_width-1:0] data_rdata,
  input  logic                               data_awvalid,
  output logic                               data_awready,
  input  logic [mem_sys_pkg::addr_width-1:0] data_awaddr,
  input  logic                               data_wvalid,
  output logic                               data_wready,
  input  logic [mem_sys_pkg::data_width-1:0] data_wdata,
  input  logic [mem_sys_pkg::strb_width-1:0] data_wstrb,
  output logic                               data_bvalid,
  input  logic                               data_bready,
  output logic                               req_valid,
  input  logic                               req_ready,
  output mem_sys_pkg::mem_op_t               req_op,
  output logic [mem_sys_pkg::addr_width-1:0] req_addr,
  output logic [mem_sys_pkg::data_width-1:0] req_wdata,
  output logic [mem_sys_pkg::strb_width-1:0] req_wstrb,
  input  logic                               rsp_valid,
  input  logic [mem_sys_pkg::data_width-1:0] rsp_rdata
);

  localparam int idx_bits = $clog2(num_sets);
  localparam int tag_bits = mem_sys_pkg::addr_width - idx_bits - mem_sys_pkg::word_lsb;

  logic [mem_sys_pkg::data_width-1:0] data_arr [num_sets];
  logic [tag_bits-1:0]                tag_arr  [num_sets];
  logic [num_sets-1:0]                valid_q;
  logic [num_sets-1:0]                dirty_q;
  mem_sys_pkg::cache_state_t          state_q;

  // request held while a miss is serviced
  logic                               sv_is_read;
  logic [mem_sys_pkg::addr_width-1:0] sv_addr;
  logic [mem_sys_pkg::data_width-1:0] sv_wdata;
  logic [mem_sys_pkg::strb_width-1:0] sv_wstrb;
  logic [idx_bits-1:0]                sv_idx;
  logic [tag_bits-1:0]                sv_tag;

  logic                               ready;
  logic [mem_sys_pkg::addr_width-1:0] addr;
  logic [idx_bits-1:0]                idx;
  logic [tag_bits-1:0]                tag;
  logic                               hit;
  logic                               rd_acc;
  logic                               wr_acc;
  logic                               miss_acc;

  function automatic logic [mem_sys_pkg::data_width-1:0] merge_bytes(
    input logic [mem_sys_pkg::data_width-1:0] old_word,
    input logic [mem_sys_pkg::data_width-1:0] new_word,
    input logic [mem_sys_pkg::strb_width-1:0] strb
  );
    logic [mem_sys_pkg::data_width-1:0] result;
    result = old_word;
    for (int b = 0; b < mem_sys_pkg::strb_width; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // one request in flight, so all three channels share one ready
  assign ready        = (state_q == mem_sys_pkg::cache_idle) && !data_rvalid && !data_bvalid;
  assign data_arready = ready;
  assign data_awready = ready;
  assign data_wready  = ready;

  assign addr     = data_arvalid ? data_araddr : data_awaddr;
  assign idx      = addr[mem_sys_pkg::word_lsb +: idx_bits];
  assign tag      = addr[mem_sys_pkg::addr_width-1 -: tag_bits];
  assign hit      = valid_q[idx] && (tag_arr[idx] == tag);
  assign rd_acc   = data_arvalid && ready;
  assign wr_acc   = data_awvalid && data_wvalid && ready;
  assign miss_acc = (rd_acc || wr_acc) && !hit;

  assign sv_idx = sv_addr[mem_sys_pkg::word_lsb +: idx_bits];
  assign sv_tag = sv_addr[mem_sys_pkg::addr_width-1 -: tag_bits];

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q     <= mem_sys_pkg::cache_idle;
      valid_q     <= '0;
      dirty_q     <= '0;
      data_rvalid <= 1'b0;
      data_bvalid <= 1'b0;
      req_valid   <= 1'b0;
    end else begin
      if (data_rvalid && data_rready) begin
        data_rvalid <= 1'b0;
      end
      if (data_bvalid && data_bready) begin
        data_bvalid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end

      case (state_q)
        mem_sys_pkg::cache_idle: begin
          if (rd_acc && hit) begin
            data_rvalid <= 1'b1;
          end
          if (wr_acc && hit) begin
            data_bvalid  <= 1'b1;
            dirty_q[idx] <= 1'b1;
          end
          if (miss_acc) begin
            req_valid <= 1'b1;
            state_q   <= dirty_q[idx] ? mem_sys_pkg::cache_writeback : mem_sys_pkg::cache_refill;
          end
        end
        mem_sys_pkg::cache_writeback: begin
          // victim is safe in memory, fetch the new line
          if (rsp_valid) begin
            req_valid <= 1'b1;
            state_q   <= mem_sys_pkg::cache_refill;
          end
        end
        mem_sys_pkg::cache_refill: begin
          if (rsp_valid) begin
            valid_q[sv_idx] <= 1'b1;
            dirty_q[sv_idx] <= 1'b0;
            state_q         <= mem_sys_pkg::cache_respond;
          end
        end
        default: begin
          // line is present now, finish as a hit
          if (sv_is_read) begin
            data_rvalid <= 1'b1;
          end else begin
            data_bvalid     <= 1'b1;
            dirty_q[sv_idx] <= 1'b1;
          end
          state_q <= mem_sys_pkg::cache_idle;
        end
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (rd_acc || wr_acc) begin
      sv_is_read <= rd_acc;
      sv_addr    <= addr;
      sv_wdata   <= data_wdata;
      sv_wstrb   <= data_wstrb;
    end
    if (rd_acc && hit) begin
      data_rdata <= data_arr[idx];
    end
    if (wr_acc && hit) begin
      data_arr[idx] <= merge_bytes(data_arr[idx], data_wdata, data_wstrb);
    end
    if (miss_acc) begin
      req_op    <= dirty_q[idx] ? mem_sys_pkg::mem_write : mem_sys_pkg::mem_read;
      req_addr  <= dirty_q[idx] ? {tag_arr[idx], idx, {mem_sys_pkg::word_lsb{1'b0}}} : addr;
      req_wdata <= data_arr[idx];
      req_wstrb <= '1;
    end
    if (state_q == mem_sys_pkg::cache_writeback && rsp_valid) begin
      req_op   <= mem_sys_pkg::mem_read;
      req_addr <= sv_addr;
    end
    if (state_q == mem_sys_pkg::cache_refill && rsp_valid) begin
      data_arr[sv_idx] <= rsp_rdata;
      tag_arr[sv_idx]  <= sv_tag;
    end
    if (state_q == mem_sys_pkg::cache_respond) begin
      if (sv_is_read) begin
        data_rdata <= data_arr[sv_idx];
      end else begin
        data_arr[sv_idx] <= merge_bytes(data_arr[sv_idx], sv_wdata, sv_wstrb);
      end
    end
  end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               f_req_valid,
  output logic                               f_req_ready,
  input  logic [mem_sys_pkg::addr_width-1:0] f_req_addr,
  output logic                               f_rsp_valid,
  output logic [mem_sys_pkg::data_width-1:0] f_rsp_rdata,
  input  logic                               c_req_valid,
  output logic                               c_req_ready,
  input  mem_sys_pkg::mem_op_t               c_req_op,
  input  logic [mem_sys_pkg::addr_width-1:0] c_req_addr,
  input  logic [mem_sys_pkg::data_width-1:0] c_req_wdata,
  input  logic [mem_sys_pkg::strb_width-1:0] c_req_wstrb,
  output logic                               c_rsp_valid,
  output logic [mem_sys_pkg::data_width-1:0] c_rsp_rdata,
  output logic                               m_req_valid,
  input  logic                               m_req_ready,
  output mem_sys_pkg::mem_op_t               m_req_op,
  output logic [mem_sys_pkg::addr_width-1:0] m_req_addr,
  output logic [mem_sys_pkg::data_width-1:0] m_req_wdata,
  output logic [mem_sys_pkg::strb_width-1:0] m_req_wstrb,
  input  logic                               m_rsp_valid,
  input  logic [mem_sys_pkg::data_width-1:0] m_rsp_rdata
);

  // last winner, which is also the owner while busy
  mem_sys_pkg::grant_t last_q;
  logic                busy_q;
  mem_sys_pkg::grant_t sel;
  logic                sel_cache;

  always_comb begin
    if (f_req_valid && c_req_valid) begin
      sel = (last_q == mem_sys_pkg::grant_fetch) ? mem_sys_pkg::grant_cache
                                                 : mem_sys_pkg::grant_fetch;
    end else if (c_req_valid) begin
      sel = mem_sys_pkg::grant_cache;
    end else begin
      sel = mem_sys_pkg::grant_fetch;
    end
  end

  assign sel_cache   = (sel == mem_sys_pkg::grant_cache);
  assign m_req_valid = !busy_q && (f_req_valid || c_req_valid);
  assign f_req_ready = !busy_q && !sel_cache && m_req_ready;
  assign c_req_ready = !busy_q && sel_cache && m_req_ready;

  // fetch requests are always reads
  assign m_req_op    = sel_cache ? c_req_op : mem_sys_pkg::mem_read;
  assign m_req_addr  = sel_cache ? c_req_addr : f_req_addr;
  assign m_req_wdata = sel_cache ? c_req_wdata : '0;
  assign m_req_wstrb = sel_cache ? c_req_wstrb : '0;

  assign f_rsp_valid = m_rsp_valid && busy_q && (last_q == mem_sys_pkg::grant_fetch);
  assign c_rsp_valid = m_rsp_valid && busy_q && (last_q == mem_sys_pkg::grant_cache);
  assign f_rsp_rdata = m_rsp_rdata;
  assign c_rsp_rdata = m_rsp_rdata;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      busy_q <= 1'b0;
      last_q <= mem_sys_pkg::grant_cache;
    end else if (m_req_valid && m_req_ready) begin
      busy_q <= 1'b1;
      last_q <= sel;
    end else if (m_rsp_valid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

/* rtl/word_memory.sv */
`timescale 1ns/1ps

module word_memory #(
  parameter int mem_words = 1024
) (
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               req_valid,
  output logic                               req_ready,
  input  mem_sys_pkg::mem_op_t               req_op,
  input  logic [mem_sys_pkg::addr_width-1:0] req_addr,
  input  logic [mem_sys_pkg::data_width-1:0] req_wdata,
  input  logic [mem_sys_pkg::strb_width-1:0] req_wstrb,
  output logic                               rsp_valid,
  output logic [mem_sys_pkg::data_width-1:0] rsp_rdata
);

  localparam int idx_bits = $clog2(mem_words);

  logic [mem_sys_pkg::data_width-1:0] mem_arr [mem_words];
  logic [idx_bits-1:0]                idx;
  logic                               accept;

  assign idx    = req_addr[mem_sys_pkg::word_lsb +: idx_bits];
  assign accept = req_valid && req_ready;

  // the single port takes a new request in every cycle
  assign req_ready = 1'b1;

  // contents start cleared
  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem_arr[i] = '0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= accept;
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      rsp_rdata <= mem_arr[idx];
      if (req_op == mem_sys_pkg::mem_write) begin
        for (int b = 0; b < mem_sys_pkg::strb_width; b++) begin
          if (req_wstrb[b]) begin
            mem_arr[idx][8*b +: 8] <= req_wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

/* rtl/mem_sys_top.sv */
`timescale 1ns/1ps

module mem_sys_top #(
  parameter int num_sets  = 4,
  parameter int mem_words = 1024
) (
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               fetch_arvalid,
  output logic                               fetch_arready,
  input  logic [mem_sys_pkg::addr_width-1:0] fetch_araddr,
  output logic                               fetch_rvalid,
  input  logic                               fetch_rready,
  output logic [mem_sys_pkg::data_width-1:0] fetch_rdata,
  input  logic                               data_arvalid,
  output logic                               data_arready,
  input  logic [mem_sys_pkg::addr_width-1:0] data_araddr,
  output logic                               data_rvalid,
  input  logic                               data_rready,
  output logic [mem_sys_pkg::data_width-1:0] data_rdata,
  input  logic                               data_awvalid,
  output logic                               data_awready,
  input  logic [mem_sys_pkg::addr_width-1:0] data_awaddr,
  input  logic                               data_wvalid,
  output logic                               data_wready,
  input  logic [mem_sys_pkg::data_width-1:0] data_wdata,
  input  logic [mem_sys_pkg::strb_width-1:0] data_wstrb,
  output logic                               data_bvalid,
  input  logic                               data_bready
);

  // fetch port to arbiter
  logic                               f_req_valid;
  logic                               f_req_ready;
  logic [mem_sys_pkg::addr_width-1:0] f_req_addr;
  logic                               f_rsp_valid;
  logic [mem_sys_pkg::data_width-1:0] f_rsp_rdata;

  // cache to arbiter
  logic                               c_req_valid;
  logic                               c_req_ready;
  mem_sys_pkg::mem_op_t               c_req_op;
  logic [mem_sys_pkg::addr_width-1:0] c_req_addr;
  logic [mem_sys_pkg::data_width-1:0] c_req_wdata;
  logic [mem_sys_pkg::strb_width-1:0] c_req_wstrb;
  logic                               c_rsp_valid;
  logic [mem_sys_pkg::data_width-1:0] c_rsp_rdata;

  // arbiter to memory
  logic                               m_req_valid;
  logic                               m_req_ready;
  mem_sys_pkg::mem_op_t               m_req_op;
  logic [mem_sys_pkg::addr_width-1:0] m_req_addr;
  logic [mem_sys_pkg::data_width-1:0] m_req_wdata;
  logic [mem_sys_pkg::strb_width-1:0] m_req_wstrb;
  logic                               m_rsp_valid;
  logic [mem_sys_pkg::data_width-1:0] m_rsp_rdata;

  fetch_port i_fetch_port (
    .ACLK          (ACLK),
    .ARESETn       (ARESETn),
    .fetch_arvalid (fetch_arvalid),
    .fetch_arready (fetch_arready),
    .fetch_araddr  (fetch_araddr),
    .fetch_rvalid  (fetch_rvalid),
    .fetch_rready  (fetch_rready),
    .fetch_rdata   (fetch_rdata),
    .req_valid     (f_req_valid),
    .req_ready     (f_req_ready),
    .req_addr      (f_req_addr),
    .rsp_valid     (f_rsp_valid),
    .rsp_rdata     (f_rsp_rdata)
  );

  wb_cache #(
    .num_sets (num_sets)
  ) i_wb_cache (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .data_arvalid (data_arvalid),
    .data_arready (data_arready),
    .data_araddr  (data_araddr),
    .data_rvalid  (data_rvalid),
    .data_rready  (data_rready),
    .data_rdata   (data_rdata),
    .data_awvalid (data_awvalid),
    .data_awready (data_awready),
    .data_awaddr  (data_awaddr),
    .data_wvalid  (data_wvalid),
    .data_wready  (data_wready),
    .data_wdata   (data_wdata),
    .data_wstrb   (data_wstrb),
    .data_bvalid  (data_bvalid),
    .data_bready  (data_bready),
    .req_valid    (c_req_valid),
    .req_ready    (c_req_ready),
    .req_op       (c_req_op),
    .req_addr     (c_req_addr),
    .req_wdata    (c_req_wdata),
    .req_wstrb    (c_req_wstrb),
    .rsp_valid    (c_rsp_valid),
    .rsp_rdata    (c_rsp_rdata)
  );

  mem_arbiter i_mem_arbiter (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .f_req_valid (f_req_valid),
    .f_req_ready (f_req_ready),
    .f_req_addr  (f_req_addr),
    .f_rsp_valid (f_rsp_valid),
    .f_rsp_rdata (f_rsp_rdata),
    .c_req_valid (c_req_valid),
    .c_req_ready (c_req_ready),
    .c_req_op    (c_req_op),
    .c_req_addr  (c_req_addr),
    .c_req_wdata (c_req_wdata),
    .c_req_wstrb (c_req_wstrb),
    .c_rsp_valid (c_rsp_valid),
    .c_rsp_rdata (c_rsp_rdata),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_op    (m_req_op),
    .m_req_addr  (m_req_addr),
    .m_req_wdata (m_req_wdata),
    .m_req_wstrb (m_req_wstrb),
    .m_rsp_valid (m_rsp_valid),
    .m_rsp_rdata (m_rsp_rdata)
  );

  word_memory #(
    .mem_words (mem_words)
  ) i_word_memory (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .req_valid (m_req_valid),
    .req_ready (m_req_ready),
    .req_op    (m_req_op),
    .req_addr  (m_req_addr),
    .req_wdata (m_req_wdata),
    .req_wstrb (m_req_wstrb),
    .rsp_valid (m_rsp_valid),
    .rsp_rdata (m_rsp_rdata)
  );

endmodule

/* tb/mem_sys_chk.sv */
`timescale 1ns/1ps

module mem_sys_chk (
  input logic                               ACLK,
  input logic                               ARESETn,
  input logic                               fetch_rvalid,
  input logic                               fetch_rready,
  input logic [mem_sys_pkg::data_width-1:0] fetch_rdata,
  input logic                               data_rvalid,
  input logic                               data_rready,
  input logic [mem_sys_pkg::data_width-1:0] data_rdata,
  input logic                               data_bvalid,
  input logic                               data_bready
);

  int fail_count = 0;

  // a stalled response keeps its valid and its data
  fetch_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_rdata))
    else begin
      $error("fetch read response changed while stalled");
      fail_count = fail_count + 1;
    end

  data_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    data_rvalid && !data_rready |=> data_rvalid && $stable(data_rdata))
    else begin
      $error("data read response changed while stalled");
      fail_count = fail_count + 1;
    end

  data_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    data_bvalid && !data_bready |=> data_bvalid)
    else begin
      $error("data write response dropped while stalled");
      fail_count = fail_count + 1;
    end

  // nothing is pending once reset has been seen
  reset_quiet: assert property (@(posedge ACLK)
    !ARESETn |=> !fetch_rvalid && !data_rvalid && !data_bvalid)
    else begin
      $error("valid output high after reset");
      fail_count = fail_count + 1;
    end

endmodule

bind mem_sys_top mem_sys_chk i_mem_sys_chk (
  .ACLK         (ACLK),
  .ARESETn      (ARESETn),
  .fetch_rvalid (fetch_rvalid),
  .fetch_rready (fetch_rready),
  .fetch_rdata  (fetch_rdata),
  .data_rvalid  (data_rvalid),
  .data_rready  (data_rready),
  .data_rdata   (data_rdata),
  .data_bvalid  (data_bvalid),
  .data_bready  (data_bready)
);

/* tb/mem_sys_tb.sv */
`timescale 1ns/1ps

module mem_sys_tb;

  localparam int num_sets = 4;
  localparam int max_wait = 200;

  logic                               ACLK;
  logic                               ARESETn;
  logic                               fetch_arvalid;
  logic                               fetch_arready;
  logic [mem_sys_pkg::addr_width-1:0] fetch_araddr;
  logic                               fetch_rvalid;
  logic                               fetch_rready;
  logic [mem_sys_pkg::data_width-1:0] fetch_rdata;
  logic                               data_arvalid;
  logic                               data_arready;
  logic [mem_sys_pkg::addr_width-1:0] data_araddr;
  logic                               data_rvalid;
  logic                               data_rready;
  logic [mem_sys_pkg::data_width-1:0] data_rdata;
  logic                               data_awvalid;
  logic                               data_awready;
  logic [mem_sys_pkg::addr_width-1:0] data_awaddr;
  logic                               data_wvalid;
  logic                               data_wready;
  logic [mem_sys_pkg::data_width-1:0] data_wdata;
  logic [mem_sys_pkg::strb_width-1:0] data_wstrb;
  logic                               data_bvalid;
  logic                               data_bready;

  logic [31:0] rng_state;
  // byte-addressed image of what the data port has written
  logic [7:0]  model_bytes [int];
  logic [31:0] fetch_expect [$];
  string       cur_test;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;

  initial ACLK = 1'b0;
  always #50 ACLK = ~ACLK;

  mem_sys_top #(
    .num_sets  (num_sets),
    .mem_words (1024)
  ) i_mem_sys_top (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [31:0] word;
    word = '0;
    for (int b = 0; b < 4; b++) begin
      if (model_bytes.exists(addr + b)) begin
        word[8*b +: 8] = model_bytes[addr + b];
      end
    end
    return word;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_bytes[addr + b] = wdata[8*b +: 8];
      end
    end
  endtask

  // failures of the bound protocol checks count as well
  function int total_errors();
    return errors + i_mem_sys_top.i_mem_sys_chk.fail_count;
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error: %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task abort_run(input string why);
    $display("%s: %s", cur_test, why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic step_wait(inout int waited, input string why);
    @(posedge ACLK);
    #1;
    waited++;
    if (waited > max_wait) begin
      abort_run(why);
    end
  endtask

  // hold ready low for a few cycles so the response must wait
  task automatic stall_random();
    int n;
    n = next_rand() % 4;
    repeat (n) begin
      @(posedge ACLK);
      #1;
    end
  endtask

  task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb);
    int waited;
    waited = 0;
    data_awaddr  = addr;
    data_wdata   = wdata;
    data_wstrb   = strb;
    data_awvalid = 1'b1;
    data_wvalid  = 1'b1;
    while (!(data_awready && data_wready)) begin
      step_wait(waited, "data write was never accepted");
    end
    @(posedge ACLK);
    #1;
    data_awvalid = 1'b0;
    data_wvalid  = 1'b0;
    model_write(addr, wdata, strb);
    waited = 0;
    while (!data_bvalid) begin
      step_wait(waited, "data write response never arrived");
    end
    stall_random();
    data_bready = 1'b1;
    @(posedge ACLK);
    #1;
    data_bready = 1'b0;
  endtask

  task automatic data_read_check(input logic [31:0] addr, input string what);
    int          waited;
    logic [31:0] exp;
    exp          = model_read(addr);
    waited       = 0;
    data_araddr  = addr;
    data_arvalid = 1'b1;
    while (!data_arready) begin
      step_wait(waited, "data read was never accepted");
    end
    @(posedge ACLK);
    #1;
    data_arvalid = 1'b0;
    waited       = 0;
    while (!data_rvalid) begin
      step_wait(waited, "data read response never arrived");
    end
    stall_random();
    check_word(what, exp, data_rdata);
    data_rready = 1'b1;
    @(posedge ACLK);
    #1;
    data_rready = 1'b0;
  endtask

  task automatic fetch_issue(input logic [31:0] addr);
    int waited;
    waited = 0;
    fetch_expect.push_back(model_read(addr));
    fetch_araddr  = addr;
    fetch_arvalid = 1'b1;
    while (!fetch_arready) begin
      step_wait(waited, "fetch read was never accepted");
    end
    @(posedge ACLK);
    #1;
    fetch_arvalid = 1'b0;
  endtask

  task automatic fetch_collect(input string what);
    int waited;
    waited = 0;
    while (!fetch_rvalid) begin
      step_wait(waited, "fetch read response never arrived");
    end
    stall_random();
    check_word(what, fetch_expect.pop_front(), fetch_rdata);
    fetch_rready = 1'b1;
    @(posedge ACLK);
    #1;
    fetch_rready = 1'b0;
  endtask

  // addresses go out back to back while responses are stalled, so the buffer fills
  task automatic fetch_stream(input logic [31:0] base, input int count, input string what);
    fork
      for (int i = 0; i < count; i++) begin
        fetch_issue(base + 4 * i);
      end
      for (int j = 0; j < count; j++) begin
        fetch_collect(what);
      end
    join
  endtask

  task automatic random_data_ops(input logic [31:0] base, input int words, input int count);
    logic [31:0] addr;
    logic [31:0] rnd;
    for (int k = 0; k < count; k++) begin
      rnd  = next_rand();
      addr = base + 4 * (rnd % words);
      if (rnd[8]) begin
        data_read_check(addr, "random read");
      end else begin
        data_write(addr, next_rand(), rnd[12:9]);
      end
    end
  endtask

  task finish_test(input int errors_before);
    tests_run++;
    if (total_errors() == errors_before) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, total_errors() - errors_before);
    end
  endtask

  initial begin
    int          mark;
    logic [31:0] a;
    rng_state     = 32'd40355;
    checks        = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cur_test      = "reset";
    ARESETn       = 1'b0;
    fetch_arvalid = 1'b0;
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    data_arvalid  = 1'b0;
    data_araddr   = '0;
    data_rready   = 1'b0;
    data_awvalid  = 1'b0;
    data_awaddr   = '0;
    data_wvalid   = 1'b0;
    data_wdata    = '0;
    data_wstrb    = '0;
    data_bready   = 1'b0;
    repeat (3) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;
    @(posedge ACLK);
    #1;

    cur_test = "unwritten_zero";
    mark     = total_errors();
    data_read_check(32'h000, "data read");
    fetch_stream(32'h400, 1, "fetch read");
    finish_test(mark);

    cur_test = "write_read";
    mark     = total_errors();
    data_write(32'h020, 32'hcafe_f00d, 4'hf);
    data_read_check(32'h020, "read back");
    finish_test(mark);

    cur_test = "byte_strobes";
    mark     = total_errors();
    data_write(32'h030, 32'h1122_3344, 4'hf);
    for (int i = 0; i < 6; i++) begin
      a = next_rand();
      data_write(32'h030, next_rand(), a[3:0]);
      data_read_check(32'h030, "merged word");
    end
    finish_test(mark);

    // second write lands on the same line and pushes the first one out
    cur_test = "dirty_eviction";
    mark     = total_errors();
    a        = 32'h040;
    data_write(a, 32'h5a5a_0001, 4'hf);
    data_write(a + num_sets * 4, 32'ha5a5_0002, 4'hf);
    fetch_stream(a, 1, "fetch of evicted word");
    data_read_check(a, "data read of evicted word");
    finish_test(mark);

    cur_test = "back_pressure";
    mark     = total_errors();
    for (int i = 0; i < 8; i++) begin
      data_write(32'h100 + 4 * i, next_rand(), 4'hf);
    end
    // one more write per set moves the rest of 0x100..0x11c into memory
    for (int i = 0; i < num_sets; i++) begin
      data_write(32'h200 + 4 * i, next_rand(), 4'hf);
    end
    fork
      fetch_stream(32'h100, 8, "fetch under stall");
      random_data_ops(32'h200, 8, 16);
    join
    finish_test(mark);

    cur_test = "concurrent";
    mark     = total_errors();
    fork
      fetch_stream(32'h800, 12, "fetch of untouched region");
      random_data_ops(32'h300, 16, 24);
    join
    finish_test(mark);

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
rtl/mem_sys_pkg.sv
rtl/fetch_port.sv
rtl/wb_cache.sv
rtl/mem_arbiter.sv
rtl/word_memory.sv
rtl/mem_sys_top.sv
tb/mem_sys_chk.sv
tb/mem_sys_tb.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - files:
      - rtl/mem_sys_pkg.sv
      - rtl/fetch_port.sv
      - rtl/wb_cache.sv
      - rtl/mem_arbiter.sv
      - rtl/word_memory.sv
      - rtl/mem_sys_top.sv
  - target: test
    files:
      - tb/mem_sys_chk.sv
      - tb/mem_sys_tb.sv
